/* verilog/settings_pkg.sv */
// bridge settings register map
// setting field widths and config word bit positions
// adapter assignment modes, adapter type and dip word types

package settings_pkg;

    ////////////////////////////////////////
    // bridge addresses, exact match only

    localparam logic [31:0] addr_lives        = 32'h2000_0000;
    localparam logic [31:0] addr_difficulty   = 32'h3000_0000;
    localparam logic [31:0] addr_bonus        = 32'h4000_0000;
    localparam logic [31:0] addr_demo_sounds  = 32'h5000_0000;
    // bit 0 turns the adapter on
    localparam logic [31:0] addr_snac_enable  = 32'hF200_0000;
    localparam logic [31:0] addr_snac_config  = 32'hF700_0000;
    // any write flips the reset request
    localparam logic [31:0] addr_core_reset   = 32'h8000_0000;

    ////////////////////////////////////////
    // field widths

    localparam int lives_w      = 2;
    localparam int difficulty_w = 3;
    localparam int bonus_w      = 3;

    // adapter config word layout
    localparam int snac_cfg_type_lsb   = 0;
    localparam int snac_cfg_assign_lsb = 8;

    // adapter to player mapping
    typedef enum logic [1:0] {
        p1_to_p1     = 2'd0,
        p1_to_p2     = 2'd1,
        both_direct  = 2'd2,
        both_swapped = 2'd3
    } snac_assign_t;

    typedef logic [4:0]  snac_type_t;
    typedef logic [15:0] dip_word_t;

endpackage

/* verilog/controls_pkg.sv */
// pad word and stick word types
// key bitmap positions, stick thresholds
// analog adapter type codes, arcade control word layout

package controls_pkg;

    ////////////////////////////////////////
    // pad and stick words

    typedef logic [15:0] pad_word_t;
    // x axis low byte, y axis next byte
    typedef logic [31:0] stick_word_t;

    // key bitmap positions
    localparam int btn_up    = 0;
    localparam int btn_down  = 1;
    localparam int btn_left  = 2;
    localparam int btn_right = 3;
    localparam int btn_fire  = 4;
    localparam int btn_coin  = 14;
    localparam int btn_start = 15;

    // stick axis slices
    localparam int stick_axis_w = 8;
    localparam int stick_x_lsb  = 0;
    localparam int stick_y_lsb  = 8;

    // idle sits near 0x7f, anything outside the band is a direction
    localparam logic [7:0] stick_low  = 8'h40;
    localparam logic [7:0] stick_high = 8'hC0;

    // adapter types that report analog sticks
    localparam logic [4:0] snac_type_analog_a = 5'h12;
    localparam logic [4:0] snac_type_analog_b = 5'h13;

    ////////////////////////////////////////
    // arcade word, up in the msb down to coin in the lsb

    typedef logic [6:0] arcade_ctrl_t;

    localparam int arc_up    = 6;
    localparam int arc_down  = 5;
    localparam int arc_left  = 4;
    localparam int arc_right = 3;
    localparam int arc_fire  = 2;
    localparam int arc_start = 1;
    localparam int arc_coin  = 0;

endpackage

/* verilog/settings_regs.sv */
// bridge write decoder for the core settings
// dip switch word builder
// toggle triggered core reset stretcher

`timescale 1ns/1ns

module settings_regs #(
    parameter int RESET_HOLD_CYCLES = 2097151
) (
    input  logic                       clk_74a,
    input  logic                       reset,
    input  logic                       bridge_wr,
    input  logic [31:0]                bridge_addr,
    input  logic [31:0]                bridge_wr_data,
    output settings_pkg::dip_word_t    dip_switches,
    output logic                       snac_enable,
    output settings_pkg::snac_type_t   snac_type,
    output settings_pkg::snac_assign_t snac_assign,
    output logic                       core_reset
);

    localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

    logic [settings_pkg::lives_w-1:0]      lives;
    logic [settings_pkg::difficulty_w-1:0] difficulty;
    logic [settings_pkg::bonus_w-1:0]      bonus;
    logic                                  demo_sounds;
    logic                                  reset_req;
    logic                                  reset_req_d;
    logic                                  stretch;
    logic [CNT_W-1:0]                      stretch_cnt;

    ////////////////////////////////////////
    // bridge writes

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            lives       <= '0;
            difficulty  <= '0;
            bonus       <= '0;
            demo_sounds <= 1'b0;
            snac_enable <= 1'b0;
            snac_type   <= '0;
            snac_assign <= settings_pkg::p1_to_p1;
            reset_req   <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                settings_pkg::addr_lives:
                    lives <= bridge_wr_data[settings_pkg::lives_w-1:0];
                settings_pkg::addr_difficulty:
                    difficulty <= bridge_wr_data[settings_pkg::difficulty_w-1:0];
                settings_pkg::addr_bonus:
                    bonus <= bridge_wr_data[settings_pkg::bonus_w-1:0];
                settings_pkg::addr_demo_sounds:
                    demo_sounds <= bridge_wr_data[0];
                settings_pkg::addr_snac_enable:
                    snac_enable <= bridge_wr_data[0];
                settings_pkg::addr_snac_config: begin
                    snac_type   <= bridge_wr_data[settings_pkg::snac_cfg_type_lsb +: 5];
                    snac_assign <= settings_pkg::snac_assign_t'(
                        bridge_wr_data[settings_pkg::snac_cfg_assign_lsb +: 2]);
                end
                // request is a toggle, the stretcher looks for the change
                settings_pkg::addr_core_reset:
                    reset_req <= ~reset_req;
                default: ;
            endcase
        end
    end

    // high byte bonus then difficulty, low byte lives and demo sounds on top
    assign dip_switches = {2'b00, difficulty, bonus, demo_sounds, 5'b0_0000, lives};

    ////////////////////////////////////////
    // reset stretcher

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            reset_req_d <= 1'b0;
            stretch     <= 1'b0;
            stretch_cnt <= '0;
        end else begin
            // always track, so a toggle during the stretch is swallowed
            reset_req_d <= reset_req;
            if (stretch) begin
                if (stretch_cnt == '0) begin
                    stretch <= 1'b0;
                end else begin
                    stretch_cnt <= stretch_cnt - 1'b1;
                end
            end else if (reset_req != reset_req_d) begin
                stretch     <= 1'b1;
                stretch_cnt <= CNT_W'(RESET_HOLD_CYCLES - 1);
            end
        end
    end

    assign core_reset = stretch | reset;

endmodule

/* verilog/snac_dpad.sv */
// adapter d-pad decoder for both players
// sticks through fixed thresholds on analog types, else button bits

`timescale 1ns/1ns

module snac_dpad (
    input  logic                      clk_74a,
    input  logic                      reset,
    input  settings_pkg::snac_type_t  snac_type,
    input  controls_pkg::pad_word_t   snac_p1_btn,
    input  controls_pkg::stick_word_t snac_p1_joy,
    input  controls_pkg::pad_word_t   snac_p2_btn,
    input  controls_pkg::stick_word_t snac_p2_joy,
    output controls_pkg::pad_word_t   p1_pad,
    output controls_pkg::pad_word_t   p2_pad
);

    logic is_analog;

    // one player's word, buttons 15..4 always pass
    function automatic controls_pkg::pad_word_t decode_pad(
        input controls_pkg::pad_word_t   btn,
        input controls_pkg::stick_word_t joy,
        input logic                      analog
    );
        logic [controls_pkg::stick_axis_w-1:0] x;
        logic [controls_pkg::stick_axis_w-1:0] y;
        controls_pkg::pad_word_t               pad;

        x   = joy[controls_pkg::stick_x_lsb +: controls_pkg::stick_axis_w];
        y   = joy[controls_pkg::stick_y_lsb +: controls_pkg::stick_axis_w];
        pad = btn;
        if (analog) begin
            // y grows downward, x grows right
            pad[controls_pkg::btn_up]    = (y < controls_pkg::stick_low);
            pad[controls_pkg::btn_down]  = (y > controls_pkg::stick_high);
            pad[controls_pkg::btn_left]  = (x < controls_pkg::stick_low);
            pad[controls_pkg::btn_right] = (x > controls_pkg::stick_high);
        end
        return pad;
    endfunction

    assign is_analog = (snac_type == controls_pkg::snac_type_analog_a) ||
                       (snac_type == controls_pkg::snac_type_analog_b);

    // one register stage
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_pad <= '0;
            p2_pad <= '0;
        end else begin
            p1_pad <= decode_pad(snac_p1_btn, snac_p1_joy, is_analog);
            p2_pad <= decode_pad(snac_p2_btn, snac_p2_joy, is_analog);
        end
    end

endmodule

/* verilog/control_router.sv */
// player routing between console pads and adapter pads
// arcade control word from player one
// coin pulse stretcher on the coin release

`timescale 1ns/1ns

module control_router #(
    parameter int COIN_PULSE_CYCLES = 1048575
) (
    input  logic                       clk_74a,
    input  logic                       reset,
    input  logic                       snac_enable,
    input  settings_pkg::snac_type_t   snac_type,
    input  settings_pkg::snac_assign_t snac_assign,
    input  controls_pkg::pad_word_t    p1_pad,
    input  controls_pkg::pad_word_t    p2_pad,
    input  controls_pkg::pad_word_t    cont1_key,
    input  controls_pkg::pad_word_t    cont2_key,
    output controls_pkg::pad_word_t    p1_controls,
    output controls_pkg::pad_word_t    p2_controls,
    output controls_pkg::arcade_ctrl_t arcade_controls
);

    localparam int CNT_W = $clog2(COIN_PULSE_CYCLES + 1);

    logic             console_only;
    logic             coin_d;
    logic             coin_fall;
    logic             coin_pulse;
    logic [CNT_W-1:0] coin_cnt;

    ////////////////////////////////////////
    // player routing

    // adapter off or type 0 means console pads only
    assign console_only = !snac_enable || (snac_type == '0);

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else if (console_only) begin
            p1_controls <= cont1_key;
            p2_controls <= cont2_key;
        end else begin
            case (snac_assign)
                settings_pkg::p1_to_p1: begin
                    p1_controls <= p1_pad;
                    p2_controls <= cont1_key;
                end
                settings_pkg::p1_to_p2: begin
                    p1_controls <= cont1_key;
                    p2_controls <= p1_pad;
                end
                settings_pkg::both_direct: begin
                    p1_controls <= p1_pad;
                    p2_controls <= p2_pad;
                end
                default: begin
                    // both swapped
                    p1_controls <= p2_pad;
                    p2_controls <= p1_pad;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // coin pulse

    assign coin_fall = coin_d && !p1_controls[controls_pkg::btn_coin];

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            coin_d     <= 1'b0;
            coin_pulse <= 1'b0;
            coin_cnt   <= '0;
        end else begin
            coin_d <= p1_controls[controls_pkg::btn_coin];
            if (coin_pulse) begin
                // releases inside the pulse do not restart it
                if (coin_cnt == '0) begin
                    coin_pulse <= 1'b0;
                end else begin
                    coin_cnt <= coin_cnt - 1'b1;
                end
            end else if (coin_fall) begin
                coin_pulse <= 1'b1;
                coin_cnt   <= CNT_W'(COIN_PULSE_CYCLES - 1);
            end
        end
    end

    // arcade word, all from player one
    always_comb begin
        arcade_controls                          = '0;
        arcade_controls[controls_pkg::arc_up]    = p1_controls[controls_pkg::btn_up];
        arcade_controls[controls_pkg::arc_down]  = p1_controls[controls_pkg::btn_down];
        arcade_controls[controls_pkg::arc_left]  = p1_controls[controls_pkg::btn_left];
        arcade_controls[controls_pkg::arc_right] = p1_controls[controls_pkg::btn_right];
        arcade_controls[controls_pkg::arc_fire]  = p1_controls[controls_pkg::btn_fire];
        arcade_controls[controls_pkg::arc_start] = p1_controls[controls_pkg::btn_start];
        arcade_controls[controls_pkg::arc_coin]  = coin_pulse;
    end

endmodule

/* verilog/arcade_ctrl_top.sv */
// control front end top level
// settings registers, adapter d-pad decoder and player router

`timescale 1ns/1ns

module arcade_ctrl_top #(
    parameter int RESET_HOLD_CYCLES = 2097151,
    parameter int COIN_PULSE_CYCLES = 1048575
) (
    input  logic                       clk_74a,
    input  logic                       reset,
    // host bridge
    input  logic                       bridge_wr,
    input  logic [31:0]                bridge_addr,
    input  logic [31:0]                bridge_wr_data,
    // console pads
    input  controls_pkg::pad_word_t    cont1_key,
    input  controls_pkg::pad_word_t    cont2_key,
    // adapter pads
    input  controls_pkg::pad_word_t    snac_p1_btn,
    input  controls_pkg::stick_word_t  snac_p1_joy,
    input  controls_pkg::pad_word_t    snac_p2_btn,
    input  controls_pkg::stick_word_t  snac_p2_joy,
    output settings_pkg::dip_word_t    dip_switches,
    output logic                       core_reset,
    output controls_pkg::pad_word_t    p1_controls,
    output controls_pkg::pad_word_t    p2_controls,
    output controls_pkg::arcade_ctrl_t arcade_controls
);

    logic                       snac_enable;
    settings_pkg::snac_type_t   snac_type;
    settings_pkg::snac_assign_t snac_assign;
    controls_pkg::pad_word_t    p1_pad;
    controls_pkg::pad_word_t    p2_pad;

    ////////////////////////////////////////
    // settings and adapter decode

    settings_regs #(
        .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
    ) settings_regs_i (
        .clk_74a(clk_74a),
        .reset(reset),
        .bridge_wr(bridge_wr),
        .bridge_addr(bridge_addr),
        .bridge_wr_data(bridge_wr_data),
        .dip_switches(dip_switches),
        .snac_enable(snac_enable),
        .snac_type(snac_type),
        .snac_assign(snac_assign),
        .core_reset(core_reset)
    );

    snac_dpad snac_dpad_i (
        .clk_74a(clk_74a),
        .reset(reset),
        .snac_type(snac_type),
        .snac_p1_btn(snac_p1_btn),
        .snac_p1_joy(snac_p1_joy),
        .snac_p2_btn(snac_p2_btn),
        .snac_p2_joy(snac_p2_joy),
        .p1_pad(p1_pad),
        .p2_pad(p2_pad)
    );

    ////////////////////////////////////////
    // routing and arcade word

    control_router #(
        .COIN_PULSE_CYCLES(COIN_PULSE_CYCLES)
    ) control_router_i (
        .clk_74a(clk_74a),
        .reset(reset),
        .snac_enable(snac_enable),
        .snac_type(snac_type),
        .snac_assign(snac_assign),
        .p1_pad(p1_pad),
        .p2_pad(p2_pad),
        .cont1_key(cont1_key),
        .cont2_key(cont2_key),
        .p1_controls(p1_controls),
        .p2_controls(p2_controls),
        .arcade_controls(arcade_controls)
    );

endmodule

/* verif/tb_clock.sv */
// testbench clock source, 10 ns period
// power-on reset held for a few rising edges

`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_74a,
    output logic reset
);

    initial begin
        clk_74a = 1'b0;
        forever #(PERIOD_NS / 2) clk_74a = ~clk_74a;
    end

    // release just after an edge, same as the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_74a);
        #1 reset = 1'b0;
    end

endmodule

/* verif/arcade_ctrl_tb.sv */
// testbench for the arcade control front end
// reference model of routing, d-pad decode and dip word
// compare process, directed pulse tests, watchdog

`timescale 1ns/1ns

module arcade_ctrl_tb;

    localparam int clk_period_ns = 10;
    localparam int drive_ns      = 1;
    localparam int reset_hold    = 20;
    localparam int coin_pulse    = 8;
    // pad checks of the routing tests at six cycles each
    localparam int pad_checks    = 24 + 40 + 18;
    // plus about 40 bridge writes and the three cycle-counting loops
    localparam int est_cycles    = pad_checks * 6 + 40 * 2 + 30 + 40 + 14;
    // generous margin near 200 us
    localparam int watchdog_ns   = est_cycles * 30 * clk_period_ns;

    logic                       clk_74a;
    logic                       reset;
    logic                       bridge_wr;
    logic [31:0]                bridge_addr;
    logic [31:0]                bridge_wr_data;
    controls_pkg::pad_word_t    cont1_key;
    controls_pkg::pad_word_t    cont2_key;
    controls_pkg::pad_word_t    snac_p1_btn;
    controls_pkg::stick_word_t  snac_p1_joy;
    controls_pkg::pad_word_t    snac_p2_btn;
    controls_pkg::stick_word_t  snac_p2_joy;
    settings_pkg::dip_word_t    dip_switches;
    logic                       core_reset;
    controls_pkg::pad_word_t    p1_controls;
    controls_pkg::pad_word_t    p2_controls;
    controls_pkg::arcade_ctrl_t arcade_controls;

    // settings as the testbench expects them
    logic [1:0] m_lives;
    logic [2:0] m_diff;
    logic [2:0] m_bonus;
    logic       m_demo;
    logic       m_enable;
    logic [4:0] m_type;
    logic [1:0] m_assign;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int req_count;
    int ack_count;

    tb_clock #(
        .PERIOD_NS(clk_period_ns),
        .RESET_CYCLES(3)
    ) tb_clock_i (
        .clk_74a(clk_74a),
        .reset(reset)
    );

    arcade_ctrl_top #(
        .RESET_HOLD_CYCLES(reset_hold),
        .COIN_PULSE_CYCLES(coin_pulse)
    ) arcade_ctrl_top_i (
        .clk_74a(clk_74a),
        .reset(reset),
        .bridge_wr(bridge_wr),
        .bridge_addr(bridge_addr),
        .bridge_wr_data(bridge_wr_data),
        .cont1_key(cont1_key),
        .cont2_key(cont2_key),
        .snac_p1_btn(snac_p1_btn),
        .snac_p1_joy(snac_p1_joy),
        .snac_p2_btn(snac_p2_btn),
        .snac_p2_joy(snac_p2_joy),
        .dip_switches(dip_switches),
        .core_reset(core_reset),
        .p1_controls(p1_controls),
        .p2_controls(p2_controls),
        .arcade_controls(arcade_controls)
    );

    ////////////////////////////////////////
    // reference model

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    // 0 below low threshold, 1 inside the band, 2 above high threshold
    function automatic logic [7:0] stick_value(input int cls);
        logic [31:0] r;
        case (cls)
            0:       r = $urandom % 32'd64;
            1:       r = 32'h40 + ($urandom % 32'd129);
            default: r = 32'hC1 + ($urandom % 32'd63);
        endcase
        return r[7:0];
    endfunction

    // lives low, demo sounds bit 7, bonus 10..8, difficulty 13..11
    function automatic settings_pkg::dip_word_t dip_layout();
        settings_pkg::dip_word_t d;

        d        = '0;
        d[1:0]   = m_lives;
        d[7]     = m_demo;
        d[10:8]  = m_bonus;
        d[13:11] = m_diff;
        return d;
    endfunction

    function automatic controls_pkg::pad_word_t decode_adapter_pad(
        input controls_pkg::pad_word_t   btn,
        input controls_pkg::stick_word_t joy,
        input logic                      analog
    );
        logic [7:0]              x;
        logic [7:0]              y;
        controls_pkg::pad_word_t w;

        x = joy[7:0];
        y = joy[15:8];
        w = btn;
        if (analog) begin
            w[0] = (y < controls_pkg::stick_low);
            w[1] = (y > controls_pkg::stick_high);
            w[2] = (x < controls_pkg::stick_low);
            w[3] = (x > controls_pkg::stick_high);
        end
        return w;
    endfunction

    // coin bit left at 0
    function automatic void route_players(
        output controls_pkg::pad_word_t    p1,
        output controls_pkg::pad_word_t    p2,
        output controls_pkg::arcade_ctrl_t arc
    );
        logic                    analog;
        controls_pkg::pad_word_t a1;
        controls_pkg::pad_word_t a2;

        analog = (m_type == 5'h12) || (m_type == 5'h13);
        a1     = decode_adapter_pad(snac_p1_btn, snac_p1_joy, analog);
        a2     = decode_adapter_pad(snac_p2_btn, snac_p2_joy, analog);
        if (!m_enable || m_type == 5'd0) begin
            p1 = cont1_key;
            p2 = cont2_key;
        end else begin
            case (m_assign)
                2'd0: begin
                    p1 = a1;
                    p2 = cont1_key;
                end
                2'd1: begin
                    p1 = cont1_key;
                    p2 = a1;
                end
                2'd2: begin
                    p1 = a1;
                    p2 = a2;
                end
                default: begin
                    p1 = a2;
                    p2 = a1;
                end
            endcase
        end
        // up, down, left, right, fire, start, coin
        arc = {p1[0], p1[1], p1[2], p1[3], p1[4], p1[15], 1'b0};
    endfunction

    ////////////////////////////////////////
    // compare process

    initial begin : compare_proc
        controls_pkg::pad_word_t    exp_p1;
        controls_pkg::pad_word_t    exp_p2;
        controls_pkg::arcade_ctrl_t exp_arc;

        forever begin
            wait (req_count != ack_count);
            // four cycles for the pad path to settle then sample mid-cycle
            repeat (4) @(posedge clk_74a);
            @(negedge clk_74a);
            route_players(exp_p1, exp_p2, exp_arc);
            checks++;
            if (p1_controls !== exp_p1) begin
                $display("FAIL %0t p1_controls got %h expected %h", $time, p1_controls, exp_p1);
                errors++;
            end
            if (p2_controls !== exp_p2) begin
                $display("FAIL %0t p2_controls got %h expected %h", $time, p2_controls, exp_p2);
                errors++;
            end
            if (arcade_controls[6:1] !== exp_arc[6:1]) begin
                $display("FAIL %0t arcade_controls got %b expected %b",
                         $time, arcade_controls[6:1], exp_arc[6:1]);
                errors++;
            end
            ack_count = ack_count + 1;
        end
    end

    ////////////////////////////////////////
    // stimulus helpers

    task automatic update_model(input logic [31:0] addr, input logic [31:0] data);
        case (addr)
            settings_pkg::addr_lives:       m_lives = data[1:0];
            settings_pkg::addr_difficulty:  m_diff = data[2:0];
            settings_pkg::addr_bonus:       m_bonus = data[2:0];
            settings_pkg::addr_demo_sounds: m_demo = data[0];
            settings_pkg::addr_snac_enable: m_enable = data[0];
            settings_pkg::addr_snac_config: begin
                m_type   = data[4:0];
                m_assign = data[9:8];
            end
            default: ;
        endcase
    endtask

    // one-cycle write strobe
    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_74a);
        #(drive_ns);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        @(posedge clk_74a);
        #(drive_ns);
        bridge_wr = 1'b0;
        update_model(addr, data);
    endtask

    task automatic request_check();
        req_count = req_count + 1;
        wait (ack_count == req_count);
    endtask

    task automatic random_pads_check();
        @(posedge clk_74a);
        #(drive_ns);
        cont1_key   = rand16();
        cont2_key   = rand16();
        snac_p1_btn = rand16();
        snac_p2_btn = rand16();
        snac_p1_joy = {rand16(), rand16()};
        snac_p2_joy = {rand16(), rand16()};
        request_check();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // tests

    task automatic dip_word_writes();
        int          err0;
        int          pick;
        logic [31:0] addr;
        logic [31:0] data;

        err0 = errors;
        for (int i = 0; i < 24; i++) begin
            pick = int'($urandom % 32'd8);
            case (pick)
                0:       addr = settings_pkg::addr_lives;
                1:       addr = settings_pkg::addr_difficulty;
                2:       addr = settings_pkg::addr_bonus;
                3:       addr = settings_pkg::addr_demo_sounds;
                // near misses and unused addresses
                4:       addr = 32'h2000_0001;
                5:       addr = 32'h6000_0000;
                6:       addr = 32'h0000_0000;
                default: addr = 32'hF300_0000;
            endcase
            data = $urandom;
            bridge_write(addr, data);
            @(negedge clk_74a);
            checks++;
            if (dip_switches !== dip_layout()) begin
                $display("FAIL %0t dip_switches got %h expected %h",
                         $time, dip_switches, dip_layout());
                errors++;
            end
        end
        finish_test("dip word", err0);
    endtask

    task automatic adapter_off_passthrough();
        int err0;

        err0 = errors;
        // digital type but adapter off
        bridge_write(settings_pkg::addr_snac_config, {22'd0, 2'd2, 3'd0, 5'h05});
        bridge_write(settings_pkg::addr_snac_enable, 32'd0);
        repeat (12) random_pads_check();
        // adapter on with type 0
        bridge_write(settings_pkg::addr_snac_enable, 32'd1);
        bridge_write(settings_pkg::addr_snac_config, {22'd0, 2'd2, 8'd0});
        repeat (12) random_pads_check();
        finish_test("adapter disabled", err0);
    endtask

    task automatic digital_mode_routing();
        int          err0;
        logic [31:0] t;
        logic [1:0]  mode;

        err0 = errors;
        bridge_write(settings_pkg::addr_snac_enable, 32'd1);
        for (int m = 0; m < 4; m++) begin
            mode = m[1:0];
            // types 1..0x11 stay clear of the analog codes
            t = 32'd1 + ($urandom % 32'd17);
            bridge_write(settings_pkg::addr_snac_config, {22'd0, mode, 3'd0, t[4:0]});
            repeat (10) random_pads_check();
        end
        finish_test("digital routing", err0);
    endtask

    task automatic analog_stick_decode();
        int         err0;
        logic [4:0] types [2];

        err0     = errors;
        types[0] = 5'h12;
        types[1] = 5'h13;
        bridge_write(settings_pkg::addr_snac_enable, 32'd1);
        for (int k = 0; k < 2; k++) begin
            bridge_write(settings_pkg::addr_snac_config, {22'd0, 2'd2, 3'd0, types[k]});
            // every pairing of the three bands on both axes
            for (int xc = 0; xc < 3; xc++) begin
                for (int yc = 0; yc < 3; yc++) begin
                    @(posedge clk_74a);
                    #(drive_ns);
                    cont1_key   = rand16();
                    cont2_key   = rand16();
                    snac_p1_btn = rand16();
                    snac_p2_btn = rand16();
                    snac_p1_joy = {rand16(), stick_value(yc), stick_value(xc)};
                    snac_p2_joy = {rand16(), stick_value(2 - xc), stick_value(2 - yc)};
                    request_check();
                end
            end
        end
        finish_test("analog d-pad", err0);
    endtask

    task automatic coin_release_pulse();
        int   err0;
        int   high_count;
        int   rises;
        logic prev;

        err0       = errors;
        high_count = 0;
        rises      = 0;
        prev       = 1'b0;
        bridge_write(settings_pkg::addr_snac_enable, 32'd0);
        @(posedge clk_74a);
        #(drive_ns);
        cont1_key = '0;
        cont2_key = '0;
        // let any pulse left from random pads run out
        repeat (coin_pulse + 6) @(posedge clk_74a);
        for (int c = 0; c < 30; c++) begin
            @(posedge clk_74a);
            #(drive_ns);
            // press, release, then a second release inside the pulse
            if (c == 0 || c == 7) begin
                cont1_key = 16'h4000;
            end else if (c == 3 || c == 9) begin
                cont1_key = '0;
            end
            @(negedge clk_74a);
            if (arcade_controls[0]) begin
                high_count++;
            end
            if (arcade_controls[0] && !prev) begin
                rises++;
            end
            prev = arcade_controls[0];
        end
        checks++;
        if (high_count != coin_pulse) begin
            $display("FAIL %0t arcade_controls coin high cycles got %0d expected %0d",
                     $time, high_count, coin_pulse);
            errors++;
        end
        if (rises != 1) begin
            $display("coin pulse started %0d times instead of once", rises);
            errors++;
        end
        finish_test("coin pulse", err0);
    endtask

    task automatic core_reset_toggle();
        int   err0;
        int   high_count;
        int   rises;
        logic prev;

        err0       = errors;
        high_count = 0;
        rises      = 0;
        prev       = 1'b0;
        for (int c = 0; c < 40; c++) begin
            @(posedge clk_74a);
            #(drive_ns);
            // second toggle lands inside the stretch
            if (c == 0 || c == 8) begin
                bridge_wr      = 1'b1;
                bridge_addr    = settings_pkg::addr_core_reset;
                bridge_wr_data = $urandom;
            end else begin
                bridge_wr = 1'b0;
            end
            @(negedge clk_74a);
            if (core_reset) begin
                high_count++;
            end
            if (core_reset && !prev) begin
                rises++;
            end
            prev = core_reset;
        end
        checks++;
        if (high_count != reset_hold) begin
            $display("FAIL %0t core_reset high cycles got %0d expected %0d",
                     $time, high_count, reset_hold);
            errors++;
        end
        if (rises != 1) begin
            $display("core reset stretch started %0d times instead of once", rises);
            errors++;
        end
        finish_test("core reset stretch", err0);
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        bridge_wr      = 1'b0;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        cont2_key      = '0;
        snac_p1_btn    = '0;
        snac_p1_joy    = '0;
        snac_p2_btn    = '0;
        snac_p2_joy    = '0;
        // settings clear on reset
        m_lives        = '0;
        m_diff         = '0;
        m_bonus        = '0;
        m_demo         = 1'b0;
        m_enable       = 1'b0;
        m_type         = '0;
        m_assign       = '0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        req_count      = 0;
        ack_count      = 0;
        void'($urandom(44));
        #1;
        wait (reset == 1'b0);
        repeat (2) @(posedge clk_74a);
        dip_word_writes();
        adapter_off_passthrough();
        digital_mode_routing();
        analog_stick_decode();
        coin_release_pulse();
        core_reset_toggle();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout, tests did not finish within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sources.f */
verilog/settings_pkg.sv
verilog/controls_pkg.sv
verilog/settings_regs.sv
verilog/snac_dpad.sv
verilog/control_router.sv
verilog/arcade_ctrl_top.sv
verif/tb_clock.sv
verif/arcade_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the arcade control front end

VERILATOR ?= verilator
TOP       ?= arcade_ctrl_tb
RTL_TOP   ?= arcade_ctrl_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS := verilog/settings_pkg.sv verilog/controls_pkg.sv \
            verilog/settings_regs.sv verilog/snac_dpad.sv \
            verilog/control_router.sv verilog/arcade_ctrl_top.sv
TB_SRCS  := verif/tb_clock.sv verif/arcade_ctrl_tb.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(RTL_SRCS) $(TB_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
